/* Makefile */
SIM        = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_uart_echo
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* echo_pkg.sv */
// echo protocol constants
// frame buffer size, suffix character and idle gap that closes a frame
package echo_pkg;

	localparam int BUF_DEPTH = 64;
	localparam int ADDR_W    = 6;
	localparam int LEN_W     = 7;	// must hold BUF_DEPTH

	// two slots kept free for the suffix
	localparam logic [LEN_W-1:0] MAX_PAYLOAD = LEN_W'(BUF_DEPTH - 2);
	localparam logic [7:0]       SUFFIX_BYTE = 8'h26;	// '&'

	localparam int IDLE_W = 16;
	localparam logic [IDLE_W-1:0] IDLE_GAP_CLKS = IDLE_W'(50_000);	// 1 ms at 50 MHz

endpackage

/* echo_sequencer.sv */
`timescale 1ns/1ps
// echo sequencer
// reads a finished frame byte by byte and hands each one to the transmitter,
// then acks the frame once the last byte has gone out
module echo_sequencer import echo_pkg::*; (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              frame_req,
	input  logic [LEN_W-1:0]  frame_len,
	output logic              frame_ack,
	output logic [ADDR_W-1:0] rd_addr,
	input  logic [7:0]        rd_data,
	output logic              tx_req,
	output logic [7:0]        tx_data,
	input  logic              tx_ack
);

	logic [LEN_W-1:0] idx;
	enum logic [2:0] {SQ_WAIT, SQ_FETCH, SQ_REQ, SQ_ACK_HI, SQ_ACK_LO, SQ_DONE} state;

	assign rd_addr = idx[ADDR_W-1:0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= SQ_WAIT;
			idx       <= '0;
			frame_ack <= 1'b0;
			tx_req    <= 1'b0;
		end else begin
			case (state)
				SQ_WAIT: begin
					if (frame_req) begin
						idx   <= '0;
						state <= SQ_FETCH;
					end
				end
				SQ_FETCH: state <= SQ_REQ;	// one clock of read latency
				SQ_REQ: begin
					tx_req <= 1'b1;
					state  <= SQ_ACK_HI;
				end
				SQ_ACK_HI: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						state  <= SQ_ACK_LO;
					end
				end
				SQ_ACK_LO: begin
					if (!tx_ack) begin
						if (idx == frame_len - 1'b1) begin
							frame_ack <= 1'b1;
							state     <= SQ_DONE;
						end else begin
							idx   <= idx + 1'b1;
							state <= SQ_FETCH;
						end
					end
				end
				SQ_DONE: begin
					if (!frame_req) begin
						frame_ack <= 1'b0;
						state     <= SQ_WAIT;
					end
				end
				default: state <= SQ_WAIT;
			endcase
		end
	end

	// loaded once per byte, stays put while tx_req is high
	always_ff @(posedge sys_clk) begin
		if (state == SQ_REQ)
			tx_data <= rd_data;
	end

endmodule

/* frame_collector.sv */
`timescale 1ns/1ps
// frame collector
// stores received bytes until the line has been quiet for the idle gap,
// then appends two suffix bytes and offers the frame over req/ack
module frame_collector import echo_pkg::*; (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic [7:0]        rx_data,
	input  logic              rx_vld,
	output logic              frame_req,
	output logic [LEN_W-1:0]  frame_len,
	input  logic              frame_ack,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [7:0]        rd_data
);

	logic [7:0]        mem [BUF_DEPTH];
	logic [LEN_W-1:0]  wr_cnt;	// stored bytes, suffix included once closed
	logic [IDLE_W-1:0] idle_cnt;
	logic [ADDR_W-1:0] wr_addr;
	enum logic [1:0] {FC_LISTEN, FC_OFFER, FC_RELEASE} state;

	wire listen   = (state == FC_LISTEN);
	wire store    = listen && rx_vld && (wr_cnt < MAX_PAYLOAD);
	// gap closes IDLE_GAP_CLKS after the last rx_vld
	wire gap_done = listen && !rx_vld && (wr_cnt != '0) &&
	                (idle_cnt == IDLE_GAP_CLKS - 1'b1);

	assign wr_addr   = wr_cnt[ADDR_W-1:0];
	assign frame_len = wr_cnt;	// held steady until ack falls

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= FC_LISTEN;
			wr_cnt    <= '0;
			idle_cnt  <= '0;
			frame_req <= 1'b0;
		end else begin
			case (state)
				FC_LISTEN: begin
					if (rx_vld) begin
						idle_cnt <= '0;	// even dropped bytes restart the gap
						if (store)
							wr_cnt <= wr_cnt + 1'b1;
					end else if (gap_done) begin
						wr_cnt    <= wr_cnt + 2'd2;
						frame_req <= 1'b1;
						state     <= FC_OFFER;
					end else if (wr_cnt != '0)
						idle_cnt <= idle_cnt + 1'b1;
				end
				FC_OFFER: begin
					if (frame_ack) begin
						frame_req <= 1'b0;
						state     <= FC_RELEASE;
					end
				end
				FC_RELEASE: begin
					if (!frame_ack) begin
						wr_cnt   <= '0;
						idle_cnt <= '0;
						state    <= FC_LISTEN;
					end
				end
				default: state <= FC_LISTEN;
			endcase
		end
	end

	// buffer with registered read port
	always_ff @(posedge sys_clk) begin
		if (store)
			mem[wr_addr] <= rx_data;
		if (gap_done) begin
			mem[wr_addr]        <= SUFFIX_BYTE;
			mem[wr_addr + 1'b1] <= SUFFIX_BYTE;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* list.f */
uart_cfg_pkg.sv
echo_pkg.sv
uart_rx.sv
frame_collector.sv
echo_sequencer.sv
uart_tx.sv
uart_echo_top.sv
tb_uart_echo.sv

/* tb_uart_echo.sv */
`timescale 1ns/1ps
// testbench for the uart echo subsystem
// drives serial frames into the DUT, decodes the echo on the tx pin
// and compares it against a model of payload plus two suffix bytes
module tb_uart_echo import uart_cfg_pkg::*, echo_pkg::*;;

	localparam int BYTE_CLKS  = 10 * int'(CLKS_PER_BIT);	// one 8N1 character
	localparam int GAP_CLKS   = int'(IDLE_GAP_CLKS);
	// rx plus echoed characters and idle gaps over all tests
	localparam int TEST_BYTES = 185;
	localparam int TEST_GAPS  = 9;
	localparam int WATCHDOG_CLKS = 2 * (TEST_BYTES * BYTE_CLKS + TEST_GAPS * GAP_CLKS);

	logic       sys_clk;
	logic       sys_rst_n;
	logic       rx_line;
	logic       tx_line;
	integer     seed;
	int         frame_cnt;	// payload bytes sent in the open frame
	logic [7:0] expected_q [$];
	logic [7:0] got_q [$];

	uart_echo_top UUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (rx_line),
		.uart_tx_port (tx_line)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("ERR %s expected 0x%0h got 0x%0h", name, expected, actual));
	endtask

	task automatic pause_clks(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// start, 8 data lsb first, stop; a bad stop is held low then idled high
	task automatic send_byte(input logic [7:0] data, input logic bad_stop);
		logic [9:0] bits;
		int         i;
		bits = {~bad_stop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			rx_line <= bits[i];
			pause_clks(int'(CLKS_PER_BIT) - 1);
		end
		if (bad_stop) begin
			@(posedge sys_clk);
			rx_line <= 1'b1;
			pause_clks(int'(CLKS_PER_BIT) - 1);
		end
	endtask

	// good byte, kept in the model only while below the payload cap
	task automatic accept_byte(input logic [7:0] data);
		send_byte(data, 1'b0);
		if (frame_cnt < int'(MAX_PAYLOAD))
			expected_q.push_back(data);
		frame_cnt++;
	endtask

	task automatic end_frame();
		expected_q.push_back(SUFFIX_BYTE);
		expected_q.push_back(SUFFIX_BYTE);
		frame_cnt = 0;
	endtask

	task automatic wait_for_bytes(input int n);
		int limit;
		int cnt;
		limit = GAP_CLKS + (n + 2) * BYTE_CLKS;
		cnt = 0;
		while (got_q.size() < n) begin
			@(posedge sys_clk);
			cnt++;
			if (cnt > limit)
				abort_run($sformatf("timeout: only %0d of %0d echo bytes seen on the tx pin",
				                    got_q.size(), n));
		end
	endtask

	task automatic collect_and_compare();
		int n;
		int idx;
		n = expected_q.size();
		wait_for_bytes(n);
		for (idx = 0; idx < n; idx++)
			check($sformatf("uart_tx_port byte %0d", idx),
			      32'(expected_q.pop_front()), 32'(got_q.pop_front()));
	endtask

	task automatic test_single_byte();
		accept_byte(8'h5a);
		end_frame();
		collect_and_compare();
	endtask

	task automatic test_random_burst();
		repeat (10) accept_byte(8'($random(seed)));
		end_frame();
		collect_and_compare();
	endtask

	// short pause stays inside one frame, the echo itself splits frames
	task automatic test_frame_split();
		accept_byte(8'h31);
		pause_clks(GAP_CLKS / 2);
		accept_byte(8'h32);
		end_frame();
		collect_and_compare();
		accept_byte(8'hc7);
		end_frame();
		collect_and_compare();
	endtask

	task automatic test_payload_cap();
		repeat (70) accept_byte(8'($random(seed)));
		end_frame();
		collect_and_compare();
	endtask

	task automatic test_dropped_bytes();
		send_byte(8'hc3, 1'b1);	// framing error, never stored
		accept_byte(8'h41);
		end_frame();
		wait_for_bytes(1);
		send_byte(8'h99, 1'b0);	// lands while the echo runs
		collect_and_compare();
		accept_byte(8'h7e);
		end_frame();
		collect_and_compare();
	endtask

	// serial monitor, samples each bit of the tx pin at mid-bit
	initial begin
		logic [7:0] mon_byte;
		int         i;
		forever begin
			@(negedge tx_line);
			pause_clks(int'(HALF_BIT_CLKS));
			check("uart_tx_port start bit", 32'd0, 32'(tx_line));
			for (i = 0; i < 8; i++) begin
				pause_clks(int'(CLKS_PER_BIT));
				mon_byte[i] = tx_line;
			end
			pause_clks(int'(CLKS_PER_BIT));
			check("uart_tx_port stop bit", 32'd1, 32'(tx_line));
			got_q.push_back(mon_byte);
		end
	end

	initial begin
		pause_clks(WATCHDOG_CLKS);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		seed      = 56;
		frame_cnt = 0;
		rx_line   = 1'b1;
		sys_rst_n = 1'b0;
		repeat (10) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		pause_clks(10);
		test_single_byte();
		test_random_burst();
		test_frame_split();
		test_payload_cap();
		test_dropped_bytes();
		// nothing else may come out after the last frame
		pause_clks(GAP_CLKS + 4 * BYTE_CLKS);
		check("uart_tx_port extra bytes", 32'd0, 32'(got_q.size()));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* uart_cfg_pkg.sv */
// serial line timing shared by the uart receiver and transmitter
// bit period comes from system clock and baud rate
package uart_cfg_pkg;

	localparam int CLK_FREQ_HZ = 50_000_000;
	localparam int BAUD_RATE   = 115_200;
	localparam int BAUD_CNT_W  = 16;	// baud counter width

	// 434 clocks per bit at 50 MHz
	localparam logic [BAUD_CNT_W-1:0] CLKS_PER_BIT  = BAUD_CNT_W'(CLK_FREQ_HZ / BAUD_RATE);
	localparam logic [BAUD_CNT_W-1:0] HALF_BIT_CLKS = CLKS_PER_BIT >> 1;	// middle of start bit

	localparam int STOP_BITS = 1;	// transmit side

endpackage

/* uart_echo_top.sv */
`timescale 1ns/1ps
// uart echo subsystem
// receiver -> frame collector -> echo sequencer -> transmitter
module uart_echo_top import echo_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic uart_rx_port,
	output logic uart_tx_port
);

	logic [7:0]        rx_data;
	logic              rx_vld;
	logic              frame_req;
	logic              frame_ack;
	logic [LEN_W-1:0]  frame_len;
	logic [ADDR_W-1:0] rd_addr;
	logic [7:0]        rd_data;
	logic              tx_req;
	logic              tx_ack;
	logic [7:0]        tx_data;

	uart_rx ins_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	frame_collector ins_frame_collector (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.frame_req (frame_req),
		.frame_len (frame_len),
		.frame_ack (frame_ack),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	echo_sequencer ins_echo_sequencer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.frame_req (frame_req),
		.frame_len (frame_len),
		.frame_ack (frame_ack),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx_ack    (tx_ack)
	);

	uart_tx ins_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.tx_ack    (tx_ack),
		.tx        (uart_tx_port)
	);

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps
// uart receiver, 8N1
// start bit confirmed at half-bit, data and stop bit sampled mid-bit
// rx_vld pulses one clock for every character with a good stop bit
module uart_rx import uart_cfg_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_vld
);

	logic                  rx_meta;
	logic                  rx_sync;
	logic                  rx_prev;	// for falling edge detect
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;
	logic [7:0]            shift;
	enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} state;

	wire half_bit = (baud_cnt == HALF_BIT_CLKS - 1'b1);
	wire bit_end  = (baud_cnt == CLKS_PER_BIT - 1'b1);

	// synchronizer, line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					// edge, not level, so a low stop bit can't restart us
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (half_bit) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rx_sync ? RX_IDLE : RX_DATA;	// high again means glitch
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				RX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				RX_STOP: begin
					if (bit_end) begin
						rx_vld <= rx_sync;	// framing error drops the byte
						state  <= RX_IDLE;
					end else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first, shifts down into bit 0
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_sync, shift[7:1]};
	end

	assign rx_data = shift;

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
// uart transmitter, 8N1
// one character per four-phase req/ack, lsb first
module uart_tx import uart_cfg_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       tx_req,
	input  logic [7:0] tx_data,
	output logic       tx_ack,
	output logic       tx
);

	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [3:0]            bit_cnt;
	logic [7:0]            shift;
	enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP, TX_ACK} state;

	wire bit_end   = (baud_cnt == CLKS_PER_BIT - 1'b1);
	wire last_stop = (bit_cnt == 4'(STOP_BITS - 1));
	// last stop bit ends a clock early so ack lands 10 bit times after req,
	// the line stays high through the ack phase anyway
	wire stop_end  = last_stop ? (baud_cnt == CLKS_PER_BIT - 2'd2) : bit_end;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			tx_ack   <= 1'b0;
			tx       <= 1'b1;
		end else begin
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					if (tx_req) begin
						tx    <= 1'b0;	// start bit
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						tx      <= shift[0];
						bit_cnt <= '0;
						state   <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 4'd7) begin
							tx      <= 1'b1;
							bit_cnt <= '0;
							state   <= TX_STOP;
						end else begin
							tx      <= shift[1];	// next bit, shift moves this edge
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				TX_STOP: begin
					if (stop_end) begin
						baud_cnt <= '0;
						if (last_stop) begin
							tx_ack <= 1'b1;
							state  <= TX_ACK;
						end else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_ACK: begin
					if (!tx_req) begin
						tx_ack <= 1'b0;
						state  <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_req)
			shift <= tx_data;
		else if (state == TX_DATA && bit_end)
			shift <= shift >> 1;
	end

endmodule
